// File: source/fpslice_params.svh
// --------------------------------------------------
// FP slice parameters
// Widths, lane count, pipeline depth and tag size
// shared by the package and all slice modules
// --------------------------------------------------

`ifndef FPSLICE_PARAMS_SVH
`define FPSLICE_PARAMS_SVH

// Datapath word, one FP32 or two FP16 values
`define FPS_WIDTH 32

// SIMD lanes in the slice
`define FPS_NUM_LANES 2

// Register stages between lane input and output
`define FPS_PIPE_REGS 2

// Tag carried along with every item
`define FPS_TAG_BITS 4

`endif

// File: source/fpslice_pkg.sv
// --------------------------------------------------
// FP slice package
// Format, operation, status and data word types
// plus the canonical NaN patterns
// --------------------------------------------------

`include "fpslice_params.svh"

package fpslice_pkg;

  // Half of the datapath holds one FP16 value
  localparam int unsigned HALF_WIDTH = `FPS_WIDTH / `FPS_NUM_LANES;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_fmt_e;

  typedef enum logic [2:0] {
    MIN   = 3'd0,
    MAX   = 3'd1,
    SGNJ  = 3'd2,
    SGNJN = 3'd3,
    SGNJX = 3'd4
  } fp_op_e;

  // IEEE exception flags, only NV can be raised here
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } fp_status_t;

  // One word seen as a single FP32 or as two FP16 values
  typedef union packed {
    logic [`FPS_WIDTH-1:0]                  fp32;
    logic [`FPS_NUM_LANES-1:0][HALF_WIDTH-1:0] fp16;
  } fp_word_u;

  // Side data travelling with each item, steers packing
  typedef struct packed {
    fp_fmt_e fmt;
    logic    vector;
  } lane_aux_t;

  localparam logic [31:0] FP32_CANON_NAN = 32'h7fc0_0000;
  localparam logic [15:0] FP16_CANON_NAN = 16'h7e00;

endpackage

// File: source/fpslice_lane_if.sv
// --------------------------------------------------
// FP slice lane interface
// Input and output valid/ready handshake with data
// for one SIMD lane
// --------------------------------------------------

`timescale 1ns/10ps
`include "fpslice_params.svh"

interface fpslice_lane_if;
  import fpslice_pkg::*;

  // Input side
  logic                     in_valid;
  logic                     in_ready;
  fp_word_u                 opa;
  fp_word_u                 opb;
  fp_op_e                   op;
  fp_fmt_e                  fmt;
  lane_aux_t                aux_in;
  logic [`FPS_TAG_BITS-1:0] tag_in;

  // Output side
  logic                     out_valid;
  logic                     out_ready;
  fp_word_u                 result;
  fp_status_t               status;
  lane_aux_t                aux_out;
  logic [`FPS_TAG_BITS-1:0] tag_out;
  logic                     busy;  // Any stage holds an item

  modport issue (output in_valid, opa, opb, op, fmt, aux_in, tag_in, input in_ready);

  modport lane (input  in_valid, opa, opb, op, fmt, aux_in, tag_in, out_ready,
                output in_ready, out_valid, result, status, aux_out, tag_out, busy);

  modport collect (input out_valid, result, status, aux_out, tag_out, output out_ready);

endinterface

// File: source/fpslice_operand_unpack.sv
// --------------------------------------------------
// FP slice operand unpack
// Slices the input word into per-lane operands,
// checks FP16 NaN-boxing and gates the lane valids
// --------------------------------------------------

`timescale 1ns/10ps
`include "fpslice_params.svh"

module fpslice_operand_unpack (
  input  logic                     in_valid_i,
  input  logic                     vectorial_i,
  input  fpslice_pkg::fp_fmt_e     fmt_i,
  input  fpslice_pkg::fp_op_e      op_i,
  input  fpslice_pkg::fp_word_u    opa_i,
  input  fpslice_pkg::fp_word_u    opb_i,
  input  logic [`FPS_TAG_BITS-1:0] tag_i,
  fpslice_lane_if.issue            lane0_o,
  fpslice_lane_if.issue            lane1_o
);
  import fpslice_pkg::*;

  logic      vec_op;
  logic      scalar_fp16;
  fp_word_u  opa_chk, opb_chk;
  lane_aux_t aux;

  // Scalar FP16 values must sit under an all-ones upper half
  function automatic fp_word_u check_boxing(fp_word_u w);
    fp_word_u r;
    r = w;
    if (w.fp16[1] != '1) begin
      r.fp16[0] = FP16_CANON_NAN;
    end
    return r;
  endfunction

  // Only FP16 has a second lane, vector FP32 runs as scalar
  assign vec_op      = vectorial_i & (fmt_i == FP16);
  assign scalar_fp16 = (fmt_i == FP16) & ~vectorial_i;

  assign opa_chk = scalar_fp16 ? check_boxing(opa_i) : opa_i;
  assign opb_chk = scalar_fp16 ? check_boxing(opb_i) : opb_i;

  assign aux.fmt    = fmt_i;
  assign aux.vector = vec_op;

  // Lane 0 sees the full word, FP16 lives in the low half
  assign lane0_o.in_valid = in_valid_i;
  assign lane0_o.opa      = opa_chk;
  assign lane0_o.opb      = opb_chk;
  assign lane0_o.op       = op_i;
  assign lane0_o.fmt      = fmt_i;
  assign lane0_o.aux_in   = aux;
  assign lane0_o.tag_in   = tag_i;

  // Lane 1 gets the upper FP16 half moved down
  // Upper lane takes vectors only when lane 0 accepts them
  assign lane1_o.in_valid = in_valid_i & vec_op & lane0_o.in_ready;
  assign lane1_o.opa      = {{HALF_WIDTH{1'b1}}, opa_i.fp16[1]};
  assign lane1_o.opb      = {{HALF_WIDTH{1'b1}}, opb_i.fp16[1]};
  assign lane1_o.op       = op_i;
  assign lane1_o.fmt      = fmt_i;
  assign lane1_o.aux_in   = aux;
  assign lane1_o.tag_in   = tag_i;

endmodule

// File: source/fpslice_noncomp_lane.sv
// --------------------------------------------------
// FP slice non-computational lane
// MIN/MAX and sign injection for FP32 or FP16,
// followed by a valid/ready register pipeline
// --------------------------------------------------

`timescale 1ns/10ps
`include "fpslice_params.svh"

module fpslice_noncomp_lane #(
  parameter bit LANE_HAS_FP32 = 1'b1
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          flush_i,
  fpslice_lane_if.lane  lane_io
);
  import fpslice_pkg::*;

  localparam int unsigned NR = `FPS_PIPE_REGS;

  logic              use_fp32;
  logic              sign_a, sign_b;
  logic              nan_a, nan_b;
  logic              snan_a, snan_b;
  logic [`FPS_WIDTH-2:0] mag_a, mag_b;
  logic              a_lt_b;
  logic              sign_r;
  fp_word_u          canon_nan;
  fp_word_u          result_d;
  fp_status_t        status_d;

  // --------------------------------------------------
  // Field helpers, FP16 uses the low half
  // --------------------------------------------------
  function automatic logic is_nan(fp_word_u w, logic wide);
    if (wide) begin
      return (&w.fp32[30:23]) && (|w.fp32[22:0]);
    end
    return (&w.fp16[0][14:10]) && (|w.fp16[0][9:0]);
  endfunction

  function automatic logic quiet_bit(fp_word_u w, logic wide);
    return wide ? w.fp32[22] : w.fp16[0][9];
  endfunction

  function automatic logic sign_of(fp_word_u w, logic wide);
    return wide ? w.fp32[31] : w.fp16[0][15];
  endfunction

  function automatic logic [`FPS_WIDTH-2:0] mag_of(fp_word_u w, logic wide);
    return wide ? w.fp32[30:0] : {{HALF_WIDTH{1'b0}}, w.fp16[0][14:0]};
  endfunction

  // Rebuild a value with a new sign, FP16 comes back NaN-boxed
  function automatic fp_word_u with_sign(fp_word_u w, logic wide, logic s);
    return wide ? {s, w.fp32[30:0]} : {{HALF_WIDTH{1'b1}}, s, w.fp16[0][14:0]};
  endfunction

  // Constant folds to FP16 only on lanes without FP32
  assign use_fp32 = LANE_HAS_FP32 && (lane_io.fmt == FP32);

  assign sign_a = sign_of(lane_io.opa, use_fp32);
  assign sign_b = sign_of(lane_io.opb, use_fp32);
  assign mag_a  = mag_of(lane_io.opa, use_fp32);
  assign mag_b  = mag_of(lane_io.opb, use_fp32);
  assign nan_a  = is_nan(lane_io.opa, use_fp32);
  assign nan_b  = is_nan(lane_io.opb, use_fp32);
  assign snan_a = nan_a & ~quiet_bit(lane_io.opa, use_fp32);
  assign snan_b = nan_b & ~quiet_bit(lane_io.opb, use_fp32);

  assign canon_nan = use_fp32 ? FP32_CANON_NAN : {{HALF_WIDTH{1'b1}}, FP16_CANON_NAN};

  // Ordering of non-NaN values, -0 sorts below +0
  always_comb begin : compare
    if (sign_a != sign_b) begin
      a_lt_b = sign_a;
    end else if (sign_a) begin
      a_lt_b = mag_a > mag_b;  // Both negative
    end else begin
      a_lt_b = mag_a < mag_b;
    end
  end

  always_comb begin : operation
    status_d = '0;
    sign_r   = sign_a;
    result_d = with_sign(lane_io.opa, use_fp32, sign_a);
    unique case (lane_io.op)
      MIN, MAX: begin
        status_d.nv = snan_a | snan_b;
        if (nan_a && nan_b) begin
          result_d = canon_nan;
        end else if (nan_a) begin
          result_d = with_sign(lane_io.opb, use_fp32, sign_b);
        end else if (!nan_b && (a_lt_b == (lane_io.op == MAX))) begin
          result_d = with_sign(lane_io.opb, use_fp32, sign_b);  // b is the pick
        end
      end
      SGNJ, SGNJN, SGNJX: begin
        if (lane_io.op == SGNJ) begin
          sign_r = sign_b;
        end else if (lane_io.op == SGNJN) begin
          sign_r = ~sign_b;
        end else begin
          sign_r = sign_a ^ sign_b;
        end
        result_d = with_sign(lane_io.opa, use_fp32, sign_r);
      end
      default: ;  // Unknown op passes opa through
    endcase
  end

  // --------------------------------------------------
  // Pipeline, index i is the item after i registers
  // --------------------------------------------------
  logic                     valid_q  [0:NR];
  fp_word_u                 result_q [0:NR];
  fp_status_t               status_q [0:NR];
  lane_aux_t                aux_q    [0:NR];
  logic [`FPS_TAG_BITS-1:0] tag_q    [0:NR];
  logic [0:NR]              stage_ready;
  logic                     stage_busy;

  assign valid_q[0]  = lane_io.in_valid;
  assign result_q[0] = result_d;
  assign status_q[0] = status_d;
  assign aux_q[0]    = lane_io.aux_in;
  assign tag_q[0]    = lane_io.tag_in;

  for (genvar i = 0; i < NR; i++) begin : gen_stage
    // Advance when the next stage is empty or moving on
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (!rst_n_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && valid_q[i]) begin
        result_q[i+1] <= result_q[i];
        status_q[i+1] <= status_q[i];
        aux_q[i+1]    <= aux_q[i];
        tag_q[i+1]    <= tag_q[i];
      end
    end
  end

  assign stage_ready[NR] = lane_io.out_ready;  // Driven by the packer

  always_comb begin : busy_flag
    stage_busy = 1'b0;
    for (int i = 1; i <= NR; i++) begin
      stage_busy |= valid_q[i];
    end
  end

  assign lane_io.in_ready  = stage_ready[0];
  assign lane_io.out_valid = valid_q[NR];
  assign lane_io.result    = result_q[NR];
  assign lane_io.status    = status_q[NR];
  assign lane_io.aux_out   = aux_q[NR];
  assign lane_io.tag_out   = tag_q[NR];
  assign lane_io.busy      = stage_busy;

endmodule

// File: source/fpslice_result_pack.sv
// --------------------------------------------------
// FP slice result pack
// Merges the lane results into one word, collapses
// status and drives the output handshake
// --------------------------------------------------

`timescale 1ns/10ps
`include "fpslice_params.svh"

module fpslice_result_pack (
  fpslice_lane_if.collect          lane0_i,
  fpslice_lane_if.collect          lane1_i,
  input  logic                     out_ready_i,
  output logic                     out_valid_o,
  output fpslice_pkg::fp_word_u    result_o,
  output fpslice_pkg::fp_status_t  status_o,
  output logic [`FPS_TAG_BITS-1:0] tag_o
);
  import fpslice_pkg::*;

  lane_aux_t  aux0;
  logic       is_vec;
  logic       lane1_valid;
  fp_status_t lane0_status;
  fp_status_t lane1_status;

  // Lane 0 aux decides the layout of the whole word
  assign aux0   = lane0_i.aux_out;
  assign is_vec = aux0.vector;

  // --------------------------------------------------
  // Handshake
  // --------------------------------------------------
  assign lane0_i.out_ready = out_ready_i;
  assign lane1_i.out_ready = out_ready_i & is_vec;  // Upper lane only pops on vectors

  assign lane1_valid = lane1_i.out_valid & is_vec;
  assign out_valid_o = lane0_i.out_valid;
  assign tag_o       = lane0_i.tag_out;

  // --------------------------------------------------
  // Result packing
  // --------------------------------------------------
  always_comb begin : pack_result
    if (aux0.fmt == FP32) begin
      result_o = lane0_i.result;
    end else begin
      result_o.fp16[0] = lane0_i.result.fp16[0];
      if (is_vec) begin
        result_o.fp16[1] = lane1_i.result.fp16[0];
      end else begin
        result_o.fp16[1] = '1;  // NaN-box scalar FP16
      end
    end
  end

  // Idle lanes contribute no flags
  assign lane0_status = lane0_i.out_valid ? lane0_i.status : '0;
  assign lane1_status = lane1_valid ? lane1_i.status : '0;

  assign status_o = lane0_status | lane1_status;

endmodule

// File: source/fpslice_top.sv
// --------------------------------------------------
// FP slice top
// Two-lane SIMD slice for FP32/FP16 min/max and
// sign injection on a 32-bit datapath
// --------------------------------------------------

`timescale 1ns/10ps
`include "fpslice_params.svh"

module fpslice_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     flush_i,
  // Input handshake and operands
  input  logic                     in_valid_i,
  output logic                     in_ready_o,
  input  logic                     vectorial_i,
  input  fpslice_pkg::fp_fmt_e     fmt_i,
  input  fpslice_pkg::fp_op_e      op_i,
  input  logic [`FPS_WIDTH-1:0]    opa_i,
  input  logic [`FPS_WIDTH-1:0]    opb_i,
  input  logic [`FPS_TAG_BITS-1:0] tag_i,
  // Output handshake and result
  output logic                     out_valid_o,
  input  logic                     out_ready_i,
  output logic [`FPS_WIDTH-1:0]    result_o,
  output fpslice_pkg::fp_status_t  status_o,
  output logic [`FPS_TAG_BITS-1:0] tag_o,
  // Items in flight
  output logic                     busy_o
);

  logic [`FPS_NUM_LANES-1:0] lane_busy;

  fpslice_lane_if lane0_if ();
  fpslice_lane_if lane1_if ();

  // --------------------------------------------------
  // Input side
  // --------------------------------------------------
  fpslice_operand_unpack u_unpack (
    .in_valid_i  (in_valid_i),
    .vectorial_i (vectorial_i),
    .fmt_i       (fmt_i),
    .op_i        (op_i),
    .opa_i       (opa_i),
    .opb_i       (opb_i),
    .tag_i       (tag_i),
    .lane0_o     (lane0_if.issue),
    .lane1_o     (lane1_if.issue)
  );

  assign in_ready_o = lane0_if.in_ready;  // Lanes run in step

  // --------------------------------------------------
  // Lanes
  // --------------------------------------------------
  fpslice_noncomp_lane #(
    .LANE_HAS_FP32 (1'b1)
  ) lane0_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .lane_io (lane0_if.lane)
  );

  // Upper lane only ever handles FP16
  fpslice_noncomp_lane #(
    .LANE_HAS_FP32 (1'b0)
  ) lane1_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .lane_io (lane1_if.lane)
  );

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  fpslice_result_pack u_pack (
    .lane0_i     (lane0_if.collect),
    .lane1_i     (lane1_if.collect),
    .out_ready_i (out_ready_i),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o)
  );

  assign lane_busy = {lane1_if.busy, lane0_if.busy};
  assign busy_o    = |lane_busy;

endmodule

// File: test/tb_fpslice_vectors.svh
// --------------------------------------------------
// FP slice test vectors
// Directed table of operands with expected results
// and the reference model for random rows
// --------------------------------------------------

`ifndef TB_FPSLICE_VECTORS_SVH
`define TB_FPSLICE_VECTORS_SVH

localparam int FIXED_ROWS = 22;
localparam int RAND_ROWS  = 40;
localparam int TOTAL_ROWS = FIXED_ROWS + RAND_ROWS;

typedef struct packed {
  fp_op_e                   op;
  fp_fmt_e                  fmt;
  logic                     vec;
  logic [31:0]              a;
  logic [31:0]              b;
  logic [`FPS_TAG_BITS-1:0] tag;
  logic [31:0]              exp_res;
  logic [4:0]               exp_st;   // NV DZ OF UF NX
} row_t;

row_t rows [TOTAL_ROWS];

// One value, FP32 when wide, else FP16 in bits 15:0; returns {nv, result}
function automatic logic [32:0] model_op(fp_op_e op, logic [31:0] a, logic [31:0] b, bit wide);
  logic [31:0] sgn, expm, manm, qbit, cnan, wmask, ka, kb, res;
  logic        na, nb, nv;
  sgn   = wide ? 32'h8000_0000 : 32'h0000_8000;
  expm  = wide ? 32'h7f80_0000 : 32'h0000_7c00;
  manm  = wide ? 32'h007f_ffff : 32'h0000_03ff;
  qbit  = wide ? 32'h0040_0000 : 32'h0000_0200;
  cnan  = wide ? 32'h7fc0_0000 : 32'h0000_7e00;
  wmask = wide ? 32'hffff_ffff : 32'h0000_ffff;
  na = ((a & expm) == expm) && ((a & manm) != 0);
  nb = ((b & expm) == expm) && ((b & manm) != 0);
  // Ordering key, unsigned compare gives -0 below +0
  ka = (((a & sgn) != 0) ? ~a : (a | sgn)) & wmask;
  kb = (((b & sgn) != 0) ? ~b : (b | sgn)) & wmask;
  nv  = 1'b0;
  res = a;
  case (op)
    MIN, MAX: begin
      nv = (na && (a & qbit) == 0) || (nb && (b & qbit) == 0);
      if (na && nb) res = cnan;
      else if (na) res = b;
      else if (nb) res = a;
      else res = ((ka < kb) == (op == MIN)) ? a : b;
    end
    SGNJ:    res = (a & ~sgn) | (b & sgn);
    SGNJN:   res = (a & ~sgn) | (~b & sgn);
    SGNJX:   res = a ^ (b & sgn);
    default: res = a;
  endcase
  return {nv, res};
endfunction

// Whole output word for one item; returns {status, result}
function automatic logic [36:0] expect_word(fp_op_e op, fp_fmt_e fmt, logic vec,
                                            logic [31:0] a, logic [31:0] b);
  logic [32:0] lo, hi;
  logic [15:0] a16, b16;
  if (fmt == FP32) begin
    lo = model_op(op, a, b, 1'b1);
    return {lo[32], 4'b0, lo[31:0]};
  end
  if (vec) begin
    lo = model_op(op, {16'h0, a[15:0]}, {16'h0, b[15:0]}, 1'b0);
    hi = model_op(op, {16'h0, a[31:16]}, {16'h0, b[31:16]}, 1'b0);
    return {lo[32] | hi[32], 4'b0, hi[15:0], lo[15:0]};
  end
  a16 = (a[31:16] == 16'hffff) ? a[15:0] : 16'h7e00;  // Unboxed input reads as NaN
  b16 = (b[31:16] == 16'hffff) ? b[15:0] : 16'h7e00;
  lo  = model_op(op, {16'h0, a16}, {16'h0, b16}, 1'b0);
  return {lo[32], 4'b0, 16'hffff, lo[15:0]};
endfunction

task automatic set_row(int i, fp_op_e op, fp_fmt_e fmt, logic vec, logic [31:0] a,
                       logic [31:0] b, logic [31:0] res, logic [4:0] st);
  rows[i] = '{op, fmt, vec, a, b, i[`FPS_TAG_BITS-1:0], res, st};
endtask

// op, fmt, vector, opa, opb, expected result, expected status
task automatic load_fixed_rows();
  set_row(0,  MIN,   FP32, 0, 32'h0000_0000, 32'h8000_0000, 32'h8000_0000, 5'h00);
  set_row(1,  MAX,   FP32, 0, 32'h0000_0000, 32'h8000_0000, 32'h0000_0000, 5'h00);
  set_row(2,  MIN,   FP32, 0, 32'h3f80_0000, 32'h7fc0_0001, 32'h3f80_0000, 5'h00);
  set_row(3,  MAX,   FP32, 0, 32'h7fc0_0000, 32'hc000_0000, 32'hc000_0000, 5'h00);
  set_row(4,  MIN,   FP32, 0, 32'h7fc1_2345, 32'hffc0_0000, 32'h7fc0_0000, 5'h00);
  set_row(5,  MAX,   FP32, 0, 32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, 5'h10);
  set_row(6,  MIN,   FP32, 0, 32'hbf80_0000, 32'hc000_0000, 32'hc000_0000, 5'h00);
  set_row(7,  MAX,   FP32, 0, 32'h3fc0_0000, 32'h4000_0000, 32'h4000_0000, 5'h00);
  set_row(8,  MIN,   FP32, 1, 32'h4000_0000, 32'h3f80_0000, 32'h3f80_0000, 5'h00);
  set_row(9,  MIN,   FP16, 1, 32'h3c00_8000, 32'h4000_0000, 32'h3c00_8000, 5'h00);
  set_row(10, MAX,   FP16, 1, 32'h7c01_3c00, 32'h3c00_c000, 32'h3c00_3c00, 5'h10);
  set_row(11, MIN,   FP16, 1, 32'h7e00_7e00, 32'h7e01_4000, 32'h7e00_4000, 5'h00);
  set_row(12, MAX,   FP16, 0, 32'hffff_3c00, 32'hffff_4000, 32'hffff_4000, 5'h00);
  set_row(13, MIN,   FP16, 0, 32'h0000_3c00, 32'hffff_c000, 32'hffff_c000, 5'h00);
  set_row(14, MIN,   FP16, 0, 32'h1234_3c00, 32'h0000_4000, 32'hffff_7e00, 5'h00);
  set_row(15, SGNJ,  FP32, 0, 32'h3f80_0000, 32'h8000_0000, 32'hbf80_0000, 5'h00);
  set_row(16, SGNJN, FP32, 0, 32'h3f80_0000, 32'h8000_0000, 32'h3f80_0000, 5'h00);
  set_row(17, SGNJX, FP32, 0, 32'hbf80_0000, 32'hc000_0000, 32'h3f80_0000, 5'h00);
  set_row(18, SGNJ,  FP32, 0, 32'h7f80_0001, 32'h0000_0000, 32'h7f80_0001, 5'h00);
  set_row(19, SGNJN, FP16, 1, 32'hbc00_3c00, 32'h8000_0000, 32'h3c00_bc00, 5'h00);
  set_row(20, SGNJX, FP16, 0, 32'hffff_bc00, 32'hffff_c000, 32'hffff_3c00, 5'h00);
  set_row(21, SGNJ,  FP16, 1, 32'h7c01_7c01, 32'h8000_0000, 32'hfc01_7c01, 5'h00);
endtask

`endif

// File: test/tb_fpslice.sv
// --------------------------------------------------
// FP slice testbench
// Streams the vector table through the slice and
// checks results, back-pressure, reset and flush
// --------------------------------------------------

`timescale 1ns/10ps
`include "fpslice_params.svh"

module tb_fpslice;
  import fpslice_pkg::*;

  `include "tb_fpslice_vectors.svh"

  localparam int CYCLE_LIMIT = TOTAL_ROWS * 8 + 200;

  logic                     clk_i = 1'b0;
  logic                     rst_n_i, flush_i, in_valid_i, in_ready_o, vectorial_i;
  fp_fmt_e                  fmt_i;
  fp_op_e                   op_i;
  logic [`FPS_WIDTH-1:0]    opa_i, opb_i, result_o;
  logic [`FPS_TAG_BITS-1:0] tag_i, tag_o;
  logic                     out_valid_o, busy_o;
  logic                     out_ready_i = 1'b1;
  fp_status_t               status_o;

  logic [31:0] rng = 32'h5168855a;
  int          exp_q[$];      // Row indices in issue order
  int          out_idx;
  int          errors, checks, test_start, tests_run, tests_bad, cycles;
  int          ready_mode;    // 0 always ready, 1 random, 2 held low

  fpslice_top dut_i (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  // --------------------------------------------------
  // Output side: ready pattern, checker, timeout
  // --------------------------------------------------
  always @(posedge clk_i) begin
    if (ready_mode == 1) begin
      rng = xorshift(rng);
      out_ready_i <= rng[7] | rng[3];  // Ready about 3 cycles in 4
    end else begin
      out_ready_i <= (ready_mode == 0);
    end
  end

  always @(posedge clk_i) begin
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected output at %0t with tag %0d, no item was pending", $time, tag_o);
        errors++;
      end else begin
        out_idx = exp_q.pop_front();
        checks++;
        if (result_o !== rows[out_idx].exp_res || status_o !== rows[out_idx].exp_st ||
            tag_o !== rows[out_idx].tag) begin
          $display("MISMATCH at %0t: row %0d got tag %0d result %h status %b, expected %0d %h %b",
                   $time, out_idx, tag_o, result_o, status_o, rows[out_idx].tag,
                   rows[out_idx].exp_res, rows[out_idx].exp_st);
          errors++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the DUT stopped moving items", cycles);
      $display("tests failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic build_random_rows();
    int          i;
    logic [31:0] a, b;
    logic [36:0] e;
    fp_op_e      op;
    logic        vec;
    for (i = FIXED_ROWS; i < TOTAL_ROWS; i++) begin
      rng = xorshift(rng);
      a   = rng;
      rng = xorshift(rng);
      b   = rng;
      rng = xorshift(rng);
      op  = fp_op_e'(3'(rng % 5));
      vec = rng[3];
      if (!vec && rng[4]) begin  // Mostly boxed scalars, some not
        a[31:16] = '1;
        b[31:16] = '1;
      end
      if (rng[5]) a[14:10] = '1;  // Push toward NaN in the low half
      if (rng[6]) b[30:26] = '1;
      e = expect_word(op, FP16, vec, a, b);
      set_row(i, op, FP16, vec, a, b, e[31:0], e[36:32]);
    end
  endtask

  task automatic drive_row(int i);
    in_valid_i  <= 1'b1;
    op_i        <= rows[i].op;
    fmt_i       <= rows[i].fmt;
    vectorial_i <= rows[i].vec;
    opa_i       <= rows[i].a;
    opb_i       <= rows[i].b;
    tag_i       <= rows[i].tag;
  endtask

  task automatic send_rows(int first, int last);
    int i;
    i = first;
    while (i <= last) begin
      drive_row(i);
      @(posedge clk_i);
      if (in_ready_o) begin
        exp_q.push_back(i);
        i++;
      end
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (3) @(posedge clk_i);  // Catch stray outputs
  endtask

  // Fill both lanes under back-pressure, then flush them away
  task automatic flush_stream();
    int taken;
    taken      = 0;
    ready_mode <= 2;
    @(posedge clk_i);
    while (taken < 2) begin
      drive_row(9 + taken);
      @(posedge clk_i);
      if (in_ready_o) taken++;
    end
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(posedge clk_i);
    flush_i    <= 1'b0;
    ready_mode <= 0;
    @(posedge clk_i);
    if (busy_o !== 1'b0 || out_valid_o !== 1'b0) begin
      $display("Flush at %0t left items in the pipeline", $time);
      errors++;
    end
    send_rows(0, 11);
    drain();
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (errors != test_start) begin
      tests_bad++;
      $display("Test %-14s FAIL with %0d errors", name, errors - test_start);
    end else begin
      $display("Test %-14s ok", name);
    end
    test_start = errors;
  endtask

  initial begin
    rst_n_i     <= 1'b0;
    flush_i     <= 1'b0;
    in_valid_i  <= 1'b0;
    vectorial_i <= 1'b0;
    fmt_i       <= FP32;
    op_i        <= MIN;
    opa_i       <= '0;
    opb_i       <= '0;
    tag_i       <= '0;
    load_fixed_rows();
    build_random_rows();
    repeat (10) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    if (out_valid_o !== 1'b0 || busy_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("Outputs are not idle after reset at %0t", $time);
      errors++;
    end
    finish_test("reset");
    send_rows(0, FIXED_ROWS - 1);
    drain();
    finish_test("directed");
    send_rows(FIXED_ROWS, TOTAL_ROWS - 1);
    drain();
    finish_test("random fp16");
    ready_mode <= 1;
    send_rows(0, TOTAL_ROWS - 1);
    drain();
    ready_mode <= 0;
    finish_test("back-pressure");
    flush_stream();
    finish_test("flush");
    $display("Summary: %0d tests, %0d with errors, %0d items checked, %0d errors",
             tests_run, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+source
+incdir+test
source/fpslice_pkg.sv
source/fpslice_lane_if.sv
source/fpslice_operand_unpack.sv
source/fpslice_noncomp_lane.sv
source/fpslice_result_pack.sv
source/fpslice_top.sv
test/tb_fpslice.sv

// File: Makefile
# Verilator build and run for the FP slice testbench

VERILATOR ?= verilator
TOP       ?= tb_fpslice
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	  echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
